// ==== Makefile ====
SIM     = verilator
FLAGS   = --binary --timing -Wno-fatal
TOP     = tb_adc_input
FLIST   = list.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(shell grep -v '^+' $(FLIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/adc_input_macros.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, counts and register map of the adc receive front end
// include wherever a width or an offset is needed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ADC_INPUT_MACROS_SVH
`define ADC_INPUT_MACROS_SVH

`define ADC_CHANNELS      8             // sample lanes, frame lane not counted
`define ADC_LANE_W        10            // bits per lane word
`define ADC_IN_W          90            // deserializer word, nine lanes interleaved
`define ADC_FRAME_PATTERN 10'b1111100000 // frame lane when word is aligned
`define ADC_SLIP_WAIT     4             // settle cycles after a bitslip
`define ADC_PIXEL_SIZE    256           // beats per pixel window
`define ADC_STREAM_W      128           // 8 lanes x 16 bit slots
`define ADC_CAP_LANES     3             // debug capture memories
`define ADC_CAP_DEPTH     256           // samples per capture
`define ADC_CAP_AW        8             // capture memory address bits
`define AXIL_AW           13
`define AXIL_DW           32
`define REG_CTRL          13'h000       // [0] start, [2:1] lane group
`define REG_STATUS        13'h004       // [0] busy, [1] locked, [15:8] slips
`define CAP_BASE          13'h1000      // capture memories, read only
`define CAP_LANE_STRIDE   13'h400       // bytes per capture lane

`endif

// ==== design/adc_input_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane, address and state types shared by the adc front end
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_input_macros.svh"

package adc_input_pkg;

  typedef logic [`ADC_LANE_W-1:0] lane_t;                 // one sample word
  typedef lane_t [`ADC_CHANNELS-1:0] lanes_t;             // all sample lanes, 80 bits
  typedef logic [`ADC_CAP_AW-1:0] cap_addr_t;
  typedef logic [1:0] lane_sel_t;                         // capture lane group
  typedef logic [7:0] slip_cnt_t;                         // saturates at 255

  typedef enum logic [1:0] {
    COMPARE,                                              // check frame lane
    SLIP,                                                 // bitslip pulse out
    WAIT                                                  // let deserializer shift
  } align_state_t;

  typedef enum logic {
    IDLE,
    RUN                                                   // writing capture memories
  } cap_state_t;

  typedef enum logic [1:0] {
    AX_IDLE,
    AX_WAIT,                                              // capture memory read cycle
    AX_RESP                                               // b or r valid held
  } axil_state_t;

endpackage

// ==== design/adc_input_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adc receive front end: alignment, pixel stream, debug capture
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_input_macros.svh"
`timescale 1ns/1ps

module adc_input_top (
  input  logic                     clk_adc,
  input  logic                     lresetn_adc,
  input  logic [`ADC_IN_W-1:0]     data_in,               // from serial to parallel block
  output logic                     slip,
  input  logic                     go,
  output logic                     m_tvalid,
  output logic [`ADC_STREAM_W-1:0] m_tdata,
  output logic                     m_tlast,
  output logic                     pixel_done,
  input  logic [`AXIL_AW-1:0]      s_axil_awaddr,
  input  logic                     s_axil_awvalid,
  output logic                     s_axil_awready,
  input  logic [`AXIL_DW-1:0]      s_axil_wdata,
  input  logic [`AXIL_DW/8-1:0]    s_axil_wstrb,
  input  logic                     s_axil_wvalid,
  output logic                     s_axil_wready,
  output logic [1:0]               s_axil_bresp,
  output logic                     s_axil_bvalid,
  input  logic                     s_axil_bready,
  input  logic [`AXIL_AW-1:0]      s_axil_araddr,
  input  logic                     s_axil_arvalid,
  output logic                     s_axil_arready,
  output logic [`AXIL_DW-1:0]      s_axil_rdata,
  output logic [1:0]               s_axil_rresp,
  output logic                     s_axil_rvalid,
  input  logic                     s_axil_rready
);
  import adc_input_pkg::*;

  lanes_t    lanes;                                       // aligned sample lanes
  logic      locked;
  slip_cnt_t slip_count;

  capture_rd_if cap_if ();

  frame_aligner i_frame_aligner (
    .clk_adc     (clk_adc),
    .lresetn_adc (lresetn_adc),
    .data_in     (data_in),
    .lanes       (lanes),
    .slip        (slip),
    .locked      (locked),
    .slip_count  (slip_count)
  );

  pixel_framer i_pixel_framer (
    .clk_adc     (clk_adc),
    .lresetn_adc (lresetn_adc),
    .go          (go),
    .lanes       (lanes),
    .m_tvalid    (m_tvalid),
    .m_tlast     (m_tlast),
    .pixel_done  (pixel_done),
    .m_tdata     (m_tdata)
  );

  capture_buffer i_capture_buffer (
    .clk_adc     (clk_adc),
    .lresetn_adc (lresetn_adc),
    .lanes       (lanes),
    .cap         (cap_if.buffer)
  );

  axil_regs i_axil_regs (
    .clk_adc        (clk_adc),
    .lresetn_adc    (lresetn_adc),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .locked         (locked),
    .slip_count     (slip_count),
    .cap            (cap_if.ctrl)
  );

endmodule

// ==== design/axil_regs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// axi4-lite slave: control, status and capture memory read back
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_input_macros.svh"
`timescale 1ns/1ps

module axil_regs (
  input  logic                     clk_adc,
  input  logic                     lresetn_adc,
  input  logic [`AXIL_AW-1:0]      s_axil_awaddr,
  input  logic                     s_axil_awvalid,
  output logic                     s_axil_awready,
  input  logic [`AXIL_DW-1:0]      s_axil_wdata,
  input  logic [`AXIL_DW/8-1:0]    s_axil_wstrb,
  input  logic                     s_axil_wvalid,
  output logic                     s_axil_wready,
  output logic [1:0]               s_axil_bresp,
  output logic                     s_axil_bvalid,
  input  logic                     s_axil_bready,
  input  logic [`AXIL_AW-1:0]      s_axil_araddr,
  input  logic                     s_axil_arvalid,
  output logic                     s_axil_arready,
  output logic [`AXIL_DW-1:0]      s_axil_rdata,
  output logic [1:0]               s_axil_rresp,
  output logic                     s_axil_rvalid,
  input  logic                     s_axil_rready,
  input  logic                     locked,
  input  adc_input_pkg::slip_cnt_t slip_count,
  capture_rd_if.ctrl               cap
);
  import adc_input_pkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int         LANE_SH     = $clog2(`CAP_LANE_STRIDE); // lane field position

  axil_state_t wr_state;
  axil_state_t rd_state;
  lane_sel_t   lane_sel_q;
  logic        start_q;
  logic        wr_go;                                     // aw and w taken together
  logic        rd_go;
  logic        cap_hit;

  // write channel
  assign wr_go          = (wr_state == AX_IDLE) && s_axil_awvalid && s_axil_wvalid;
  assign s_axil_awready = wr_go;
  assign s_axil_wready  = wr_go;
  assign s_axil_bvalid  = (wr_state == AX_RESP);          // held until bready

  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      wr_state   <= AX_IDLE;
      lane_sel_q <= '0;
      start_q    <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (wr_state)
        AX_IDLE: begin
          if (wr_go) begin
            wr_state <= AX_RESP;
            if (s_axil_awaddr == `REG_CTRL && s_axil_wstrb[0]) begin
              lane_sel_q <= s_axil_wdata[2:1];
              start_q    <= s_axil_wdata[0];              // self clearing
            end
          end
        end
        AX_RESP: if (s_axil_bready) wr_state <= AX_IDLE;
        default: wr_state <= AX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_adc) begin
    if (wr_go)
      s_axil_bresp <= (s_axil_awaddr == `REG_CTRL) ? RESP_OKAY : RESP_SLVERR;
  end

  assign cap.start    = start_q;
  assign cap.lane_sel = lane_sel_q;

  // read channel
  assign rd_go          = (rd_state == AX_IDLE) && s_axil_arvalid;
  assign s_axil_arready = rd_go;
  assign s_axil_rvalid  = (rd_state == AX_RESP);
  assign cap_hit        = (s_axil_araddr >= `CAP_BASE) &&
                          (((s_axil_araddr - `CAP_BASE) >> LANE_SH) < `ADC_CAP_LANES);
  assign cap.rd_en      = rd_go && cap_hit;
  assign cap.rd_lane    = s_axil_araddr[LANE_SH +: 2];
  assign cap.rd_addr    = s_axil_araddr[2 +: `ADC_CAP_AW]; // word index

  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      rd_state <= AX_IDLE;
    end else begin
      case (rd_state)
        AX_IDLE: if (rd_go) rd_state <= cap_hit ? AX_WAIT : AX_RESP;
        AX_WAIT: rd_state <= AX_RESP;                     // memory data arrives
        AX_RESP: if (s_axil_rready) rd_state <= AX_IDLE;
        default: rd_state <= AX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_adc) begin
    if (rd_go) begin
      s_axil_rresp <= RESP_OKAY;
      s_axil_rdata <= '0;
      if (s_axil_araddr == `REG_CTRL)
        s_axil_rdata <= `AXIL_DW'({lane_sel_q, 1'b0});
      else if (s_axil_araddr == `REG_STATUS)
        s_axil_rdata <= `AXIL_DW'({slip_count, 6'b0, locked, cap.busy});
      else if (!cap_hit)
        s_axil_rresp <= RESP_SLVERR;                      // unmapped
    end else if (rd_state == AX_WAIT) begin
      s_axil_rdata <= `AXIL_DW'(cap.rd_data);
    end
  end

endmodule

// ==== design/capture_buffer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug capture of three selected lanes into on chip memories,
// started and read back through the register block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_input_macros.svh"
`timescale 1ns/1ps

module capture_buffer (
  input  logic                  clk_adc,
  input  logic                  lresetn_adc,
  input  adc_input_pkg::lanes_t lanes,
  capture_rd_if.buffer          cap
);
  import adc_input_pkg::*;

  cap_state_t  state;
  cap_addr_t   wr_addr;
  lane_sel_t   sel_q;                                     // group taken at start
  lane_sel_t   sel;
  logic [2:0]  base;                                      // first lane of group
  lane_t       grp_q [`ADC_CAP_LANES];                    // stage before the write
  lane_t       rd_word [`ADC_CAP_LANES];
  logic [1:0]  rd_lane_q;

  assign sel  = cap.start ? cap.lane_sel : sel_q;
  assign base = (sel == 2'd3) ? 3'd5 : {sel, 1'b0};       // 0,2,4 then 5..7

  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      state   <= IDLE;
      wr_addr <= '0;
      sel_q   <= '0;
    end else if (cap.start) begin
      state   <= RUN;
      wr_addr <= '0;
      sel_q   <= cap.lane_sel;
    end else if (state == RUN) begin
      if (wr_addr == cap_addr_t'(`ADC_CAP_DEPTH - 1))
        state <= IDLE;
      else
        wr_addr <= wr_addr + 1'b1;
    end
  end

  assign cap.busy = (state == RUN);

  for (genvar g = 0; g < `ADC_CAP_LANES; g++) begin : g_mem
    lane_t mem [`ADC_CAP_DEPTH];

    always_ff @(posedge clk_adc) begin
      grp_q[g] <= lanes[base + g];
      if (state == RUN)
        mem[wr_addr] <= grp_q[g];
      if (cap.rd_en)
        rd_word[g] <= mem[cap.rd_addr];                   // registered read
    end
  end

  always_ff @(posedge clk_adc) begin
    if (cap.rd_en)
      rd_lane_q <= cap.rd_lane;
  end

  assign cap.rd_data = (rd_lane_q < `ADC_CAP_LANES) ? rd_word[rd_lane_q] : '0;

endmodule

// ==== design/capture_rd_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// capture control and memory read path, register block to buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_input_macros.svh"
`timescale 1ns/1ps

interface capture_rd_if;
  import adc_input_pkg::*;

  logic      start;                                       // one cycle pulse
  lane_sel_t lane_sel;                                    // held by register block
  logic      rd_en;
  logic [1:0] rd_lane;
  cap_addr_t rd_addr;
  lane_t     rd_data;                                     // one cycle after rd_en
  logic      busy;

  modport ctrl (output start, lane_sel, rd_en, rd_lane, rd_addr,
                input rd_data, busy);
  modport buffer (input start, lane_sel, rd_en, rd_lane, rd_addr,
                  output rd_data, busy);

endinterface

// ==== design/frame_aligner.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// undoes the bit interleave of the deserializer word and bitslips
// until the frame lane shows the frame pattern
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_input_macros.svh"
`timescale 1ns/1ps

module frame_aligner (
  input  logic                     clk_adc,
  input  logic                     lresetn_adc,
  input  logic [`ADC_IN_W-1:0]     data_in,
  output adc_input_pkg::lanes_t    lanes,
  output logic                     slip,
  output logic                     locked,
  output adc_input_pkg::slip_cnt_t slip_count
);
  import adc_input_pkg::*;

  localparam int NLANES = `ADC_CHANNELS + 1;              // samples plus frame
  localparam int WAIT_W = $clog2(`ADC_SLIP_WAIT + 1);

  logic [`ADC_IN_W-1:0] re_order;
  lane_t                frame_q;                          // registered frame lane
  align_state_t         state;
  logic [WAIT_W-1:0]    wait_cnt;

  // lane k bit j sits at input bit j*9+k
  for (genvar j = 0; j < `ADC_LANE_W; j++) begin : g_bit
    for (genvar k = 0; k < NLANES; k++) begin : g_lane
      assign re_order[k*`ADC_LANE_W + j] = data_in[j*NLANES + k];
    end
  end

  always_ff @(posedge clk_adc) begin
    lanes   <= re_order[`ADC_CHANNELS*`ADC_LANE_W-1:0];
    frame_q <= re_order[`ADC_IN_W-1 -: `ADC_LANE_W];      // top lane is frame
  end

  assign slip = (state == SLIP);                          // one cycle per mismatch

  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      state      <= COMPARE;
      wait_cnt   <= '0;
      locked     <= 1'b0;
      slip_count <= '0;
    end else begin
      case (state)
        COMPARE: begin
          locked <= (frame_q == `ADC_FRAME_PATTERN);
          if (frame_q != `ADC_FRAME_PATTERN) begin
            state <= SLIP;
            if (~&slip_count)
              slip_count <= slip_count + 1'b1;            // saturating
          end
        end
        SLIP: begin
          wait_cnt <= WAIT_W'(`ADC_SLIP_WAIT - 1);
          state    <= WAIT;
        end
        WAIT: begin
          if (wait_cnt == '0)
            state <= COMPARE;                             // new word has settled
          else
            wait_cnt <= wait_cnt - 1'b1;
        end
        default: state <= COMPARE;
      endcase
    end
  end

endmodule

// ==== design/pixel_framer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// go edge opens a fixed length pixel window on the sample stream
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_input_macros.svh"
`timescale 1ns/1ps

module pixel_framer (
  input  logic                      clk_adc,
  input  logic                      lresetn_adc,
  input  logic                      go,
  input  adc_input_pkg::lanes_t     lanes,
  output logic                      m_tvalid,
  output logic                      m_tlast,
  output logic                      pixel_done,
  output logic [`ADC_STREAM_W-1:0]  m_tdata
);

  localparam int CNT_W  = $clog2(`ADC_PIXEL_SIZE);
  localparam int SLOT_W = `ADC_STREAM_W / `ADC_CHANNELS;  // 16 bit slot per lane

  logic             go_d;
  logic             go_r;                                 // registered rising edge
  logic             in_pixel;
  logic             in_pixel_d;
  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk_adc or negedge lresetn_adc) begin
    if (!lresetn_adc) begin
      go_d       <= 1'b0;
      go_r       <= 1'b0;
      in_pixel   <= 1'b0;
      in_pixel_d <= 1'b0;
      cnt        <= CNT_W'(`ADC_PIXEL_SIZE - 1);
    end else begin
      go_d       <= go;
      go_r       <= go & ~go_d;
      in_pixel_d <= in_pixel;
      if (go_r) begin
        in_pixel <= 1'b1;                                 // also restarts a running window
        cnt      <= CNT_W'(`ADC_PIXEL_SIZE - 1);
      end else if (in_pixel) begin
        if (cnt == '0)
          in_pixel <= 1'b0;
        else
          cnt <= cnt - 1'b1;
      end
    end
  end

  assign m_tvalid   = in_pixel;
  assign m_tlast    = in_pixel && (cnt == '0);
  assign pixel_done = in_pixel_d & ~in_pixel;             // falling edge of window

  // no tready, downstream takes every beat
  for (genvar n = 0; n < `ADC_CHANNELS; n++) begin : g_slot
    assign m_tdata[n*SLOT_W +: SLOT_W] = SLOT_W'(lanes[n]);
  end

endmodule

// ==== list.f ====
+incdir+design
design/adc_input_pkg.sv
design/capture_rd_if.sv
design/frame_aligner.sv
design/pixel_framer.sv
design/capture_buffer.sv
design/axil_regs.sv
design/adc_input_top.sv
test/tb_adc_input.sv

// ==== test/tb_adc_input.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-checking testbench for the adc receive front end
// drives a deserializer model and an axi4-lite master and checks stream and capture
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_input_macros.svh"
`timescale 1ns/1ps

module tb_adc_input;

  localparam int NLANES       = `ADC_CHANNELS + 1;        // samples plus frame
  localparam int ALIGN_CYCLES = `ADC_LANE_W * (`ADC_SLIP_WAIT + 4) + 60;
  localparam int PIXEL_CYCLES = `ADC_PIXEL_SIZE + 20;
  localparam int READ_CYCLES  = 8;                        // worst axi read incl. handshakes
  localparam int CAP_CYCLES   = 4 * (`ADC_CAP_DEPTH + 40 +
                                     `ADC_CAP_LANES * `ADC_CAP_DEPTH * READ_CYCLES);
  localparam int REG_CYCLES   = 120;
  localparam int TIMEOUT      = 4 * (8 + ALIGN_CYCLES + PIXEL_CYCLES + CAP_CYCLES + REG_CYCLES);

  logic                     clk_adc;
  logic                     lresetn_adc;
  logic [`ADC_IN_W-1:0]     data_in;
  logic                     slip;
  logic                     go;
  logic                     m_tvalid;
  logic [`ADC_STREAM_W-1:0] m_tdata;
  logic                     m_tlast;
  logic                     pixel_done;
  logic [`AXIL_AW-1:0]      s_axil_awaddr;
  logic                     s_axil_awvalid;
  logic                     s_axil_awready;
  logic [`AXIL_DW-1:0]      s_axil_wdata;
  logic [`AXIL_DW/8-1:0]    s_axil_wstrb;
  logic                     s_axil_wvalid;
  logic                     s_axil_wready;
  logic [1:0]               s_axil_bresp;
  logic                     s_axil_bvalid;
  logic                     s_axil_bready;
  logic [`AXIL_AW-1:0]      s_axil_araddr;
  logic                     s_axil_arvalid;
  logic                     s_axil_arready;
  logic [`AXIL_DW-1:0]      s_axil_rdata;
  logic [1:0]               s_axil_rresp;
  logic                     s_axil_rvalid;
  logic                     s_axil_rready;

  int unsigned lcg_state;
  int          offset;                                    // frame rotation in bits
  int          offset0;
  int          smp;                                       // sample count now on data_in
  int          slips_seen;
  int          aw_smp;                                    // sample on data_in at aw accept
  int          cycle;
  int          errors;
  int          beats;
  int          reads;
  int          beat_cnt;
  int          windows;
  int          done_cnt;
  int          last_len;
  int          first_beat_cycle;
  int          go_cycle;
  bit          valid_d;

  adc_input_top i_adc_input_top (.*);

  initial begin
    clk_adc = 1'b0;
    forever #50 clk_adc = ~clk_adc;                       // 100 ns period
  end

  always @(posedge clk_adc) cycle <= cycle + 1;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;                               // upper bits of the state
  endfunction

  // frame pattern rotated left by off bits
  function automatic logic [`ADC_LANE_W-1:0] frame_word(input int off);
    int                       r;
    logic [2*`ADC_LANE_W-1:0] dbl;
    r   = ((off % `ADC_LANE_W) + `ADC_LANE_W) % `ADC_LANE_W;
    dbl = {`ADC_FRAME_PATTERN, `ADC_FRAME_PATTERN} << r;
    return dbl[2*`ADC_LANE_W-1 -: `ADC_LANE_W];
  endfunction

  // nine lanes interleaved so that lane k bit j lands at j*9+k
  function automatic logic [`ADC_IN_W-1:0] scramble(input int s, input int off);
    logic [`ADC_LANE_W-1:0] lane [NLANES];
    logic [`ADC_IN_W-1:0]   word;
    for (int n = 0; n < `ADC_CHANNELS; n++)
      lane[n] = `ADC_LANE_W'((s + n) % 1024);
    lane[`ADC_CHANNELS] = frame_word(off);
    for (int j = 0; j < `ADC_LANE_W; j++)
      for (int k = 0; k < NLANES; k++)
        word[j*NLANES + k] = lane[k][j];
    return word;
  endfunction

  // expected stream beat when lane 0 carries s0
  function automatic logic [`ADC_STREAM_W-1:0] expected_beat(input int s0);
    logic [`ADC_STREAM_W-1:0] beat;
    beat = '0;
    for (int n = 0; n < `ADC_CHANNELS; n++)
      beat[n*16 +: 16] = 16'((s0 + n) % 1024);            // zero padded slot
    return beat;
  endfunction

  // sample lane held by capture memory g for lane group sel
  function automatic int cap_lane(input int sel, input int g);
    return (sel == 3) ? 5 + g : 2*sel + g;
  endfunction

  function automatic logic [9:0] expected_cap(input int sel, input int g, input int first,
                                              input int a);
    return 10'((first + cap_lane(sel, g) + a) % 1024);
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("FAIL at %0t ns: %s", $time, msg);
  endtask

  // starts and ends 1 ns after a rising edge
  // bready stays low for hold cycles once the write is accepted
  task automatic axi_write(input logic [`AXIL_AW-1:0] addr, input logic [31:0] data,
                           input int hold, output logic [1:0] resp);
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_wstrb   = 4'hf;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    do @(negedge clk_adc); while (!s_axil_awready);
    if (!s_axil_wready)
      flag_error("wready not raised together with awready");
    aw_smp = smp;
    @(posedge clk_adc);
    #1;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = (hold == 0);
    repeat (hold) begin
      @(negedge clk_adc);
      if (!s_axil_bvalid)
        flag_error("bvalid dropped while bready was low");
      @(posedge clk_adc);
      #1;
    end
    s_axil_bready = 1'b1;
    do @(negedge clk_adc); while (!s_axil_bvalid);
    resp = s_axil_bresp;
    @(posedge clk_adc);
    #1;
    s_axil_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`AXIL_AW-1:0] addr, input int hold,
                          output logic [31:0] data, output logic [1:0] resp);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    do @(negedge clk_adc); while (!s_axil_arready);
    @(posedge clk_adc);
    #1;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = (hold == 0);
    do @(negedge clk_adc); while (!s_axil_rvalid);
    data = s_axil_rdata;
    resp = s_axil_rresp;
    if (hold > 0) begin
      repeat (hold) begin
        @(posedge clk_adc);
        @(negedge clk_adc);
        if (!s_axil_rvalid || s_axil_rdata !== data)
          flag_error("rvalid or rdata changed while rready was low");
      end
      @(posedge clk_adc);
      #1;
      s_axil_rready = 1'b1;
      @(negedge clk_adc);
      if (!s_axil_rvalid)
        flag_error("rvalid dropped before rready");
    end
    @(posedge clk_adc);
    #1;
    s_axil_rready = 1'b0;
    reads++;
  endtask

  // deserializer model that samples slip mid cycle and shifts in a new word after each edge
  initial begin : deser_model
    lcg_state = 32'd69;
    offset0   = int'(lcg_next() % 32);
    offset    = offset0;
    smp       = 0;
    data_in   = scramble(smp, offset);
    forever begin
      @(negedge clk_adc);
      if (slip) begin
        slips_seen++;
        offset--;                                         // one bit per slip
      end
      @(posedge clk_adc);
      #1;
      smp++;
      data_in = scramble(smp, offset);
    end
  end

  // stream compare process where lanes lag data_in by one cycle
  always @(negedge clk_adc) begin
    if (lresetn_adc) begin
      if (m_tvalid) begin
        if (beat_cnt == 0)
          first_beat_cycle = cycle;
        if (m_tdata !== expected_beat(smp - 1))
          flag_error($sformatf("beat %0d data %h, expected %h", beat_cnt, m_tdata,
                               expected_beat(smp - 1)));
        if (m_tlast !== (beat_cnt == `ADC_PIXEL_SIZE - 1))
          flag_error($sformatf("m_tlast %b on beat %0d", m_tlast, beat_cnt));
        beat_cnt++;
        beats++;
      end else if (valid_d) begin
        windows++;
        last_len = beat_cnt;
        beat_cnt = 0;
        if (!pixel_done)
          flag_error("pixel_done missing after the last beat");
      end
      if (!m_tvalid && m_tlast !== 1'b0)
        flag_error("m_tlast high outside the pixel window");
      if (pixel_done) begin
        done_cnt++;
        if (m_tvalid || !valid_d)
          flag_error("pixel_done outside the cycle after the last beat");
      end
      valid_d = m_tvalid;
    end
  end

  initial begin : watchdog
    wait (cycle >= TIMEOUT);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          polls;
    logic [9:0]  exp_word;
    lresetn_adc    = 1'b0;
    go             = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    repeat (8) @(posedge clk_adc);
    #1;
    if ({slip, m_tvalid, m_tlast, pixel_done, s_axil_awready, s_axil_wready,
         s_axil_arready, s_axil_bvalid, s_axil_rvalid} !== 9'b0)
      flag_error("outputs not low during reset");
    lresetn_adc = 1'b1;

    // poll STATUS until the frame lane locks
    do axi_read(`REG_STATUS, 0, rdata, resp); while (!rdata[1]);
    if (slips_seen != offset0 % 10)
      flag_error($sformatf("%0d slip pulses, expected %0d", slips_seen, offset0 % 10));
    if (int'(rdata[15:8]) != offset0 % 10)
      flag_error($sformatf("slip_count %0d, expected %0d", rdata[15:8], offset0 % 10));

    // one pixel window
    go       = 1'b1;
    go_cycle = cycle;
    @(posedge clk_adc);
    #1;
    go = 1'b0;
    while (windows == 0) @(posedge clk_adc);
    if (last_len != `ADC_PIXEL_SIZE)
      flag_error($sformatf("window of %0d beats", last_len));
    if (first_beat_cycle - go_cycle != 2)
      flag_error($sformatf("first beat %0d cycles after go", first_beat_cycle - go_cycle));
    if (done_cnt != 1)
      flag_error($sformatf("%0d pixel_done pulses", done_cnt));
    @(posedge clk_adc);
    #1;

    // capture for every lane group
    for (int sel = 0; sel < 4; sel++) begin
      axi_write(`REG_CTRL, 32'((sel << 1) | 1), 0, resp);
      polls = 0;
      do begin
        axi_read(`REG_STATUS, 0, rdata, resp);
        polls++;
        if (polls == 1 && !rdata[0])
          flag_error($sformatf("capture for lane group %0d did not start", sel));
      end while (rdata[0]);
      for (int g = 0; g < `ADC_CAP_LANES; g++) begin
        for (int a = 0; a < `ADC_CAP_DEPTH; a++) begin
          axi_read(`AXIL_AW'(`CAP_BASE + g*`CAP_LANE_STRIDE + a*4), 0, rdata, resp);
          exp_word = expected_cap(sel, g, aw_smp, a);
          if (resp != 2'b00 || rdata !== 32'(exp_word))
            flag_error($sformatf("group %0d lane %0d addr %0d read %h resp %0d, expected %h",
                                 sel, g, a, rdata, resp, exp_word));
        end
      end
    end

    // register access with back-pressure on b and r
    axi_write(`REG_CTRL, 32'h4, 3, resp);                 // lane group 2 without start
    if (resp != 2'b00)
      flag_error($sformatf("REG_CTRL write resp %0d", resp));
    axi_read(`REG_CTRL, 3, rdata, resp);
    if (resp != 2'b00 || rdata[2:1] != 2'd2)
      flag_error($sformatf("REG_CTRL read %h resp %0d", rdata, resp));
    axi_read(13'h008, 0, rdata, resp);
    if (resp != 2'b10)
      flag_error($sformatf("unmapped read resp %0d, expected SLVERR", resp));
    axi_read(`AXIL_AW'(`CAP_BASE + 3*`CAP_LANE_STRIDE), 0, rdata, resp);
    if (resp != 2'b10)
      flag_error($sformatf("read past capture lanes resp %0d, expected SLVERR", resp));
    axi_write(13'h008, 32'h1, 0, resp);
    if (resp != 2'b10)
      flag_error($sformatf("unmapped write resp %0d, expected SLVERR", resp));

    $display("errors %0d, stream beats %0d, axi reads %0d", errors, beats, reads);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule
